/* project.f */
+incdir+common
common/flow_pkg.sv
design/flow_mux_select.sv
design/flow_out_reg.sv
design/mux_cfg_regs.sv
design/flow_select_top.sv
verif/flow_select_chk.sv
verif/flow_select_tb.sv

/* Makefile */
# Verilator lint, simulation and cleanup for the stream selector hub

TOP := flow_select_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "tests failed" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* verif/flow_select_tb.sv */
/*
 * Testbench for the four-way stream selector hub.
 * Drives tagged push streams and config strobes on the falling edge.
 * A scoreboard queue built from push handshakes checks every output word.
 */

`timescale 1ns/1ps
`include "flow_params.svh"

module flow_select_tb;

  import flow_pkg::*;

  // Five tests of at most about 300 cycles each plus margin
  localparam int max_cycles = 2000;

  logic                                       clk;
  logic                                       rst;
  logic [`FLOW_NUM_REQ-1:0]                   push_valid;
  logic [`FLOW_NUM_REQ-1:0][`FLOW_DATA_W-1:0] push_data;
  logic [`FLOW_NUM_REQ-1:0]                   push_ready;
  logic                                       out_valid;
  logic [`FLOW_DATA_W-1:0]                    out_data;
  logic                                       out_ready;
  logic                                       cfg_wr;
  logic                                       cfg_rd;
  reg_addr_e                                  cfg_addr;
  logic [cnt_w-1:0]                           cfg_wdata;
  logic                                       cfg_rvalid;
  logic [cnt_w-1:0]                           cfg_rdata;

  // Stimulus controls set by the test sequence
  logic [`FLOW_NUM_REQ-1:0] src_on;
  logic                     rand_ready;
  logic                     tag_check;
  logic [sel_w-1:0]         cur_sel;
  logic [`FLOW_DATA_W-3:0]  src_cnt [`FLOW_NUM_REQ];

  // Scoreboard and bookkeeping
  logic [`FLOW_DATA_W-1:0]  exp_q [$];
  logic [`FLOW_DATA_W-1:0]  head;
  logic [cnt_w-1:0]         rd;
  logic                     pushed_last;
  integer                   seed;
  integer                   rnd;
  int errors;
  int err_mark;
  int tests_run;
  int cycles;
  int out_total;
  int push_total;
  int since_clr;
  int i;
  int d;
  int s;

  flow_select_top i_dut (.*);

  always #2 clk = ~clk;

  // --------------------
  // Checks and strobes
  // --------------------

  task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic cfg_write(input reg_addr_e addr, input logic [cnt_w-1:0] data);
    @(negedge clk);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk);
    cfg_wr = 1'b0;
  endtask

  task automatic cfg_read(input reg_addr_e addr, output logic [cnt_w-1:0] data);
    @(negedge clk);
    cfg_rd   = 1'b1;
    cfg_addr = addr;
    @(negedge clk);
    cfg_rd = 1'b0;
    while (!cfg_rvalid) @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic wait_outputs(input int n);
    int target;
    target = out_total + n;
    while (out_total < target) @(negedge clk);
  endtask

  // Everything accepted has left the output register
  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) $display("test %0d %s: ok", tests_run, name);
    else $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
    err_mark = errors;
  endtask

  // --------------------
  // Stimulus driver
  // --------------------

  // Tag holds the source index on top and the per-source count below
  always @(negedge clk) begin
    for (d = 0; d < `FLOW_NUM_REQ; d++) begin
      push_data[d] = {d[1:0], src_cnt[d]};
    end
    push_valid = src_on;
    if (rand_ready) begin
      rnd       = $random(seed);
      out_ready = rnd[0];
    end else begin
      out_ready = 1'b1;
    end
  end

  // --------------------
  // Monitor and scoreboard
  // --------------------

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: run still busy after %0d cycles", max_cycles);
      $display("tests failed");
      $finish;
    end else if (!rst) begin
      // A word accepted on the previous edge is on the output now
      if (pushed_last) check_eq("out_valid", 16'h1, 16'(out_valid));
      pushed_last = 1'b0;
      // Pop before push since a word pushed this edge cannot leave yet
      if (out_valid && out_ready) begin
        assert (exp_q.size() != 0) else begin
          $display("output transfer at %0t with no accepted push pending", $time);
          errors++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check_eq("out_data", head, out_data);
        end
        if (tag_check) check_eq("out_data tag", 16'(cur_sel), 16'(out_data[15:14]));
        out_total++;
        since_clr++;
      end
      if (tag_check) begin
        assert ((push_ready & ~(4'b0001 << cur_sel)) == '0) else begin
          $display("push_ready raised on an unselected source at %0t", $time);
          errors++;
        end
      end
      for (i = 0; i < `FLOW_NUM_REQ; i++) begin
        if (push_valid[i] && push_ready[i]) begin
          exp_q.push_back(push_data[i]);
          src_cnt[i]++;
          push_total++;
          pushed_last = 1'b1;
        end
      end
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    push_valid  = '0;
    push_data   = '0;
    out_ready   = 1'b0;
    cfg_wr      = 1'b0;
    cfg_rd      = 1'b0;
    cfg_addr    = REG_SELECT;
    cfg_wdata   = '0;
    src_on      = '0;
    rand_ready  = 1'b0;
    tag_check   = 1'b0;
    cur_sel     = '0;
    pushed_last = 1'b0;
    seed        = 32'hc03e_2a0d;
    for (s = 0; s < `FLOW_NUM_REQ; s++) src_cnt[s] = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    // Reset defaults
    cfg_read(REG_SELECT, rd);
    check_eq("cfg_rdata select", 16'h0, rd);
    cfg_read(REG_ENABLE, rd);
    check_eq("cfg_rdata enable", 16'h0, rd);
    cfg_read(REG_COUNT, rd);
    check_eq("cfg_rdata count", 16'h0, rd);
    repeat (10) begin
      @(negedge clk);
      check_eq("out_valid", 16'h0, 16'(out_valid));
      check_eq("push_ready", 16'h0, 16'(push_ready));
    end
    end_test("reset_defaults");

    // All sources valid with enable still low
    src_on = '1;
    repeat (50) begin
      @(negedge clk);
      check_eq("push_ready", 16'h0, 16'(push_ready));
      check_eq("out_valid", 16'h0, 16'(out_valid));
    end
    end_test("disabled");

    // Stop, reselect, restart for each source
    tag_check = 1'b1;
    for (s = 0; s < `FLOW_NUM_REQ; s++) begin
      cfg_write(REG_SELECT, 16'(s));
      cur_sel = s[sel_w-1:0];
      cfg_write(REG_ENABLE, 16'h1);
      wait_outputs(16);
      cfg_write(REG_ENABLE, 16'h0);
      wait_drain();
    end
    end_test("routing");

    // Random out_ready on a random source
    rnd = $random(seed);
    cfg_write(REG_SELECT, 16'(rnd[sel_w-1:0]));
    cur_sel    = rnd[sel_w-1:0];
    rand_ready = 1'b1;
    cfg_write(REG_ENABLE, 16'h1);
    wait_outputs(60);
    cfg_write(REG_ENABLE, 16'h0);
    wait_drain();
    check_eq("push vs out count", 16'(push_total), 16'(out_total));
    end_test("back_pressure");

    // Clear with traffic stopped, then count a burst
    cfg_write(REG_COUNT, 16'h0);
    since_clr = 0;
    cfg_write(REG_ENABLE, 16'h1);
    wait_outputs(37);
    cfg_write(REG_ENABLE, 16'h0);
    wait_drain();
    cfg_read(REG_COUNT, rd);
    check_eq("cfg_rdata count", 16'(since_clr), rd);
    cfg_write(REG_COUNT, 16'h0);
    cfg_read(REG_COUNT, rd);
    check_eq("cfg_rdata count", 16'h0, rd);
    end_test("counter");

    $display("summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* verif/flow_select_chk.sv */
/*
 * Concurrent checks for the stream selector hub, bound into the top level.
 * Covers output stability, ready steering, read timing and reset state.
 */

`timescale 1ns/1ps
`include "flow_params.svh"

module flow_select_chk (
  input logic                       clk,
  input logic                       rst,
  input logic [flow_pkg::sel_w-1:0] sel,
  input logic [`FLOW_NUM_REQ-1:0]   push_ready,
  input logic                       out_valid,
  input logic                       out_ready,
  input logic [`FLOW_DATA_W-1:0]    out_data,
  input logic                       cfg_rd,
  input logic                       cfg_rvalid
);

  // Held word stays put while stalled
  out_hold_a: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> $stable(out_data))
    else $error("out_data changed under back-pressure");

  // At most one ready, and only on the selected source
  ready_steer_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0(push_ready) && (push_ready == '0 || push_ready[sel]))
    else $error("push_ready not steered to sel");

  // --------------------
  // Read strobe timing
  // --------------------

  rd_echo_a: assert property (@(posedge clk) disable iff (rst)
    cfg_rd |=> cfg_rvalid)
    else $error("cfg_rvalid missing after cfg_rd");

  rd_quiet_a: assert property (@(posedge clk) disable iff (rst)
    !cfg_rd |=> !cfg_rvalid)
    else $error("cfg_rvalid without cfg_rd");

  // Output register comes out of reset empty
  reset_empty_a: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high after reset");

endmodule

bind flow_select_top flow_select_chk i_chk (
  .clk        (clk),
  .rst        (rst),
  .sel        (sel),
  .push_ready (push_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_data   (out_data),
  .cfg_rd     (cfg_rd),
  .cfg_rvalid (cfg_rvalid)
);

/* design/flow_select_top.sv */
/*
 * Top level of the four-way stream selector hub.
 * Connects the select mux, the output register and the config block.
 * Push handshake to out_valid takes one cycle.
 */

`timescale 1ns/1ps
`include "flow_params.svh"

module flow_select_top (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [`FLOW_NUM_REQ-1:0]                    push_valid,
  input  logic [`FLOW_NUM_REQ-1:0][`FLOW_DATA_W-1:0]  push_data,
  output logic [`FLOW_NUM_REQ-1:0]                    push_ready,
  output logic                                        out_valid,
  output logic [`FLOW_DATA_W-1:0]                     out_data,
  input  logic                                        out_ready,
  input  logic                                        cfg_wr,
  input  logic                                        cfg_rd,
  input  flow_pkg::reg_addr_e                         cfg_addr,
  input  logic [flow_pkg::cnt_w-1:0]                  cfg_wdata,
  output logic                                        cfg_rvalid,
  output logic [flow_pkg::cnt_w-1:0]                  cfg_rdata
);

  import flow_pkg::*;

  // Select and enable from software
  logic [sel_w-1:0]        sel;
  logic                    enable;

  // Mux to output register
  logic                    mux_valid;
  logic [`FLOW_DATA_W-1:0] mux_data;
  logic                    mux_ready;

  // --------------------
  // Configuration
  // --------------------

  // Counts transfers by watching the pop port
  mux_cfg_regs i_cfg (
    .clk        (clk),
    .rst        (rst),
    .cfg_wr     (cfg_wr),
    .cfg_rd     (cfg_rd),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_rvalid (cfg_rvalid),
    .cfg_rdata  (cfg_rdata),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .sel        (sel),
    .enable     (enable)
  );

  // --------------------
  // Datapath
  // --------------------

  flow_mux_select i_mux (
    .clk        (clk),
    .rst        (rst),
    .sel        (sel),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_valid  (mux_valid),
    .pop_data   (mux_data),
    .pop_ready  (mux_ready)
  );

  flow_out_reg i_out (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .in_valid  (mux_valid),
    .in_data   (mux_data),
    .in_ready  (mux_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

endmodule

/* design/mux_cfg_regs.sv */
/*
 * Configuration registers for the stream selector.
 * Single-cycle write and read strobes; read data returns one cycle later.
 * Holds the source select, the enable bit and an output transfer count.
 */

`timescale 1ns/1ps

module mux_cfg_regs (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cfg_wr,
  input  logic                       cfg_rd,
  input  flow_pkg::reg_addr_e        cfg_addr,
  input  logic [flow_pkg::cnt_w-1:0] cfg_wdata,
  output logic                       cfg_rvalid,
  output logic [flow_pkg::cnt_w-1:0] cfg_rdata,
  input  logic                       out_valid,
  input  logic                       out_ready,
  output logic [flow_pkg::sel_w-1:0] sel,
  output logic                       enable
);

  import flow_pkg::*;

  logic             count_clr;
  logic             xfer;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] rd_mux;

  // --------------------
  // Write decode
  // --------------------

  assign count_clr = cfg_wr && (cfg_addr == REG_COUNT);
  assign xfer      = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      sel    <= '0;
      enable <= 1'b0;
    end else if (cfg_wr) begin
      if (cfg_addr == REG_SELECT) begin
        sel <= cfg_wdata[sel_w-1:0];
      end
      if (cfg_addr == REG_ENABLE) begin
        enable <= cfg_wdata[0];
      end
    end
  end

  // --------------------
  // Transfer counter
  // --------------------

  // Wraps at full scale
  // A clear in the same cycle as a transfer wins
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (count_clr) begin
      count <= '0;
    end else if (xfer) begin
      count <= count + 1'b1;
    end
  end

  // --------------------
  // Read path
  // --------------------

  // Unmapped addresses read as zero
  always_comb begin
    case (cfg_addr)
      REG_SELECT: rd_mux = {{(cnt_w - sel_w){1'b0}}, sel};
      REG_ENABLE: rd_mux = {{(cnt_w - 1){1'b0}}, enable};
      REG_COUNT:  rd_mux = count;
      default:    rd_mux = '0;
    endcase
  end

  // Read strobe echoes one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_rvalid <= 1'b0;
    end else begin
      cfg_rvalid <= cfg_rd;
    end
  end

  // Captured only on a read strobe
  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      cfg_rdata <= rd_mux;
    end
  end

endmodule

/* design/flow_out_reg.sv */
/*
 * Single-entry ready-valid pipeline register at full throughput.
 * Enable gates acceptance of new words; a held word always drains.
 */

`timescale 1ns/1ps
`include "flow_params.svh"

module flow_out_reg (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,
  input  logic                    in_valid,
  input  logic [`FLOW_DATA_W-1:0] in_data,
  output logic                    in_ready,
  output logic                    out_valid,
  output logic [`FLOW_DATA_W-1:0] out_data,
  input  logic                    out_ready
);

  logic push_fire;
  logic pop_fire;

  // --------------------
  // Handshakes
  // --------------------

  // Room exists when empty or when the held word leaves this cycle
  assign in_ready  = enable && (!out_valid || out_ready);

  assign push_fire = in_valid && in_ready;
  assign pop_fire  = out_valid && out_ready;

  // --------------------
  // Valid flag
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (push_fire) begin
      // New word replaces or fills the slot
      out_valid <= 1'b1;
    end else if (pop_fire) begin
      out_valid <= 1'b0;
    end
  end

  // --------------------
  // Data register
  // --------------------

  // Loads only on accept, so data stays put under back-pressure
  always_ff @(posedge clk) begin
    if (push_fire) begin
      out_data <= in_data;
    end
  end

endmodule

/* design/flow_mux_select.sv */
/*
 * Zero-latency ready-valid mux steered by an explicit select.
 * Only the selected requester sees the pop side's ready.
 */

`timescale 1ns/1ps
`include "flow_params.svh"

module flow_mux_select (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [flow_pkg::sel_w-1:0]                  sel,
  input  logic [`FLOW_NUM_REQ-1:0]                    push_valid,
  input  logic [`FLOW_NUM_REQ-1:0][`FLOW_DATA_W-1:0]  push_data,
  output logic [`FLOW_NUM_REQ-1:0]                    push_ready,
  output logic                                        pop_valid,
  output logic [`FLOW_DATA_W-1:0]                     pop_data,
  input  logic                                        pop_ready
);

  // --------------------
  // Select range check
  // --------------------

  // Always true at the default widths
  // Catches a select past the last requester if the count stops being a power of two
  sel_in_range_a: assert property (
    @(posedge clk) disable iff (rst) sel < `FLOW_NUM_REQ
  ) else $error("flow_mux_select: select out of range");

  // --------------------
  // Datapath
  // --------------------

  // Forward valid and data of the chosen source
  assign pop_valid = push_valid[sel];
  assign pop_data  = push_data[sel];

  // Ready goes back to the chosen source only
  always_comb begin
    push_ready      = '0;
    push_ready[sel] = pop_ready;
  end

endmodule

/* common/flow_pkg.sv */
/*
 * Shared types and derived widths for the stream selector hub.
 * Holds the configuration address map used by the strobe interface.
 */

`include "flow_params.svh"

package flow_pkg;

  // Select width follows the requester count
  localparam int sel_w = $clog2(`FLOW_NUM_REQ);

  // Counter width, also config read and write data width
  localparam int cnt_w = 16;

  // Configuration register addresses
  typedef enum logic [1:0] {
    REG_SELECT = 2'd0,
    REG_ENABLE = 2'd1,
    REG_COUNT  = 2'd2
  } reg_addr_e;

endpackage

/* common/flow_params.svh */
/*
 * Width settings for the stream selector hub.
 * Include wherever requester count or data width is needed.
 */

`ifndef FLOW_PARAMS_SVH
`define FLOW_PARAMS_SVH

// Number of push requesters feeding the mux
`define FLOW_NUM_REQ 4

// Width of push and pop data words
`define FLOW_DATA_W 16

`endif
